/* hdl/conv_geom_pkg.sv */
// Layer geometry and data widths
package conv_geom_pkg;

	////////////////////////////////////////////////////////////
	// default layer shape
	////////////////////////////////////////////////////////////

	// padded input edge, host supplies the border
	localparam int W_IN_DEF = 9;
	localparam int CHIN_DEF = 2;
	localparam int CHOUT_DEF = 4;
	// output edge for a 3x3 window at stride 2
	localparam int WOUT_DEF = 4;

	// fixed window shape
	localparam int KDIM = 3;
	localparam int STRIDE = 2;

	////////////////////////////////////////////////////////////
	// data widths
	////////////////////////////////////////////////////////////

	// pixels and weights, both signed
	localparam int PIX_W = 8;
	// accumulator and bias
	localparam int ACC_W = 24;
	// unsigned quantized result
	localparam int OUT_W = 8;
	// binary point of the accumulator
	localparam int FRAC_BITS = 4;

	typedef logic signed [PIX_W-1:0] pix_t;
	typedef logic signed [ACC_W-1:0] acc_t;

endpackage

/* hdl/conv_ctrl_pkg.sv */
// Register map and control encodings
package conv_ctrl_pkg;

	localparam int APB_AW = 16;
	localparam int APB_DW = 32;

	// word index width inside one 1 KiB region
	localparam int IDX_W = 8;

	////////////////////////////////////////////////////////////
	// byte offsets
	////////////////////////////////////////////////////////////

	localparam logic [APB_AW-1:0] CTRL_ADDR = 16'h0000;
	localparam logic [APB_AW-1:0] STATUS_ADDR = 16'h0004;
	localparam logic [APB_AW-1:0] IMG_BASE = 16'h0400;
	localparam logic [APB_AW-1:0] WGT_BASE = 16'h0800;
	localparam logic [APB_AW-1:0] BIAS_BASE = 16'h0C00;
	localparam logic [APB_AW-1:0] RES_BASE = 16'h1000;

	// decoded target of an APB access
	typedef enum logic [2:0] {
		T_CTRL,
		T_STATUS,
		T_IMG,
		T_WGT,
		T_BIAS,
		T_RES,
		T_BAD
	} target_e;

	// window sequencer run states
	typedef enum logic [1:0] {
		S_IDLE,
		S_RUN,
		S_DRAIN,
		S_DONE
	} seq_state_e;

endpackage

/* hdl/conv_stream_if.sv */
// Window operand stream
`timescale 1ns/1ps

interface conv_stream_if #(
	parameter int CHOUT = 4,
	parameter int WOUT = 4
);
	import conv_geom_pkg::*;

	localparam int WIN_W = $clog2(WOUT * WOUT);

	// one beat per cycle, never stalled
	logic valid;
	// window boundaries
	logic first;
	logic last;
	// shared input pixel
	pix_t pix;
	// one weight per output channel
	pix_t wgt [CHOUT];
	// window index of this beat
	logic [WIN_W-1:0] win;

	// sequencer side
	modport src (output valid, first, last, pix, wgt, win);
	// MAC side
	modport snk (input valid, first, last, pix, wgt, win);

endinterface

/* hdl/cfg_bus_if.sv */
// Decoded memory access bus
`timescale 1ns/1ps

interface cfg_bus_if;
	import conv_ctrl_pkg::*;

	// single cycle strobes from the decoder
	logic wr_en;
	logic rd_en;
	// target already range checked
	target_e tgt;
	logic [IDX_W-1:0] idx;
	logic [APB_DW-1:0] wdata;

	// registered read data, valid a cycle after rd_en
	logic [APB_DW-1:0] img_rd_data;
	logic [APB_DW-1:0] wgt_rd_data;
	logic [APB_DW-1:0] bias_rd_data;
	logic [APB_DW-1:0] res_rd_data;

	modport master (output wr_en, rd_en, tgt, idx, wdata,
		input img_rd_data, wgt_rd_data, bias_rd_data, res_rd_data);
	modport slave_img_wgt (input wr_en, rd_en, tgt, idx, wdata,
		output img_rd_data, wgt_rd_data);
	modport slave_bias_res (input wr_en, rd_en, tgt, idx, wdata,
		output bias_rd_data, res_rd_data);

endinterface

/* hdl/apb_reg_decode.sv */
// APB register decoder
`timescale 1ns/1ps

module apb_reg_decode #(
	parameter int W_IN = 9,
	parameter int CHIN = 2,
	parameter int CHOUT = 4,
	parameter int WOUT = 4
) (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [conv_ctrl_pkg::APB_AW-1:0] paddr,
	input logic [conv_ctrl_pkg::APB_DW-1:0] pwdata,
	output logic [conv_ctrl_pkg::APB_DW-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic busy,
	input logic done,
	output logic start,
	cfg_bus_if.master cfg
);
	import conv_ctrl_pkg::*;
	import conv_geom_pkg::*;

	// region sizes in words
	localparam int IMG_WORDS = W_IN * W_IN * CHIN;
	localparam int WGT_WORDS = CHOUT * KDIM * KDIM * CHIN;
	localparam int BIAS_WORDS = CHOUT;
	localparam int RES_WORDS = WOUT * WOUT * CHOUT;
	// lowest region select bit
	localparam int RG_LO = IDX_W + 2;

	target_e tgt;
	logic [IDX_W-1:0] idx;
	logic [APB_AW-1:RG_LO] rgn;
	logic access;
	logic mem_rd;
	logic err;
	// second access cycle of a memory read
	logic rd_wait;

	assign idx = paddr[RG_LO-1:2];
	assign rgn = paddr[APB_AW-1:RG_LO];
	assign access = psel & penable;

	////////////////////////////////////////////////////////////
	// address decode, out of range folds into T_BAD
	////////////////////////////////////////////////////////////
	always_comb begin
		tgt = T_BAD;
		if (paddr == CTRL_ADDR)
			tgt = T_CTRL;
		else if (paddr == STATUS_ADDR)
			tgt = T_STATUS;
		else if (paddr[1:0] != 2'b00)
			tgt = T_BAD;
		else if (rgn == IMG_BASE[APB_AW-1:RG_LO] && int'(idx) < IMG_WORDS)
			tgt = T_IMG;
		else if (rgn == WGT_BASE[APB_AW-1:RG_LO] && int'(idx) < WGT_WORDS)
			tgt = T_WGT;
		else if (rgn == BIAS_BASE[APB_AW-1:RG_LO] && int'(idx) < BIAS_WORDS)
			tgt = T_BIAS;
		else if (rgn == RES_BASE[APB_AW-1:RG_LO] && int'(idx) < RES_WORDS)
			tgt = T_RES;
	end

	// error cases: bad address, read-only region, memory locked by a run
	always_comb begin
		case (tgt)
			T_BAD: err = 1'b1;
			T_STATUS, T_RES: err = pwrite;
			T_IMG, T_WGT, T_BIAS: err = pwrite & busy;
			default: err = 1'b0;
		endcase
	end

	assign mem_rd = ~pwrite & (tgt inside {T_IMG, T_WGT, T_BIAS, T_RES});

	// memory reads hold pready low for one cycle
	always_ff @(posedge clk) begin
		if (rst)
			rd_wait <= 1'b0;
		else
			rd_wait <= access & mem_rd & ~rd_wait;
	end

	assign pready = access & (~mem_rd | rd_wait);
	assign pslverr = pready & err;
	// start only from idle or done
	assign start = access & pwrite & (tgt == T_CTRL) & pwdata[0] & ~busy;

	assign cfg.wr_en = access & pwrite & ~err;
	assign cfg.rd_en = access & mem_rd & ~rd_wait;
	assign cfg.tgt = tgt;
	assign cfg.idx = idx;
	assign cfg.wdata = pwdata;

	// read mux, CTRL bit 0 shows the run in progress
	always_comb begin
		case (tgt)
			T_CTRL: prdata = {{(APB_DW-1){1'b0}}, busy};
			T_STATUS: prdata = {{(APB_DW-2){1'b0}}, done, busy};
			T_IMG: prdata = cfg.img_rd_data;
			T_WGT: prdata = cfg.wgt_rd_data;
			T_BIAS: prdata = cfg.bias_rd_data;
			T_RES: prdata = cfg.res_rd_data;
			default: prdata = '0;
		endcase
	end

endmodule

/* hdl/window_sequencer.sv */
// Window sequencer with image and weight storage
`timescale 1ns/1ps

module window_sequencer #(
	parameter int W_IN = 9,
	parameter int CHIN = 2,
	parameter int CHOUT = 4,
	parameter int WOUT = 4
) (
	input logic clk,
	input logic rst,
	input logic start,
	input logic store_last,
	output logic busy,
	output logic done,
	cfg_bus_if.slave_img_wgt cfg,
	conv_stream_if.src strm
);
	import conv_geom_pkg::*;
	import conv_ctrl_pkg::*;

	localparam int IMG_WORDS = W_IN * W_IN * CHIN;
	// beats per window, also the weights per lane
	localparam int K2C = KDIM * KDIM * CHIN;
	localparam int WGT_WORDS = CHOUT * K2C;
	localparam int NWIN = WOUT * WOUT;
	localparam int IMG_AW = $clog2(IMG_WORDS);
	localparam int WGT_AW = $clog2(WGT_WORDS);
	localparam int KW = $clog2(KDIM);
	localparam int CHW = $clog2(CHIN + 1);
	localparam int BW = $clog2(K2C);
	localparam int WXW = $clog2(WOUT + 1);
	localparam int WIN_W = $clog2(NWIN);

	pix_t img_mem [IMG_WORDS];
	// lane-major, each lane in beat order
	pix_t wgt_mem [WGT_WORDS];

	seq_state_e state;
	logic [KW-1:0] c_cnt;
	logic [KW-1:0] r_cnt;
	logic [CHW-1:0] ch_cnt;
	logic [BW-1:0] beat;
	logic [WXW-1:0] wx;
	logic [WIN_W-1:0] win;
	// top-left pixel of the window and of its window row
	logic [IMG_AW-1:0] ref_addr;
	logic [IMG_AW-1:0] row_ref;
	logic [IMG_AW-1:0] img_addr;
	logic issue;
	logic end_col;
	logic end_row;
	logic end_beat;
	logic end_run;

	assign issue = state == S_RUN;
	assign busy = (state == S_RUN) || (state == S_DRAIN);
	assign done = state == S_DONE;

	// beat order: column inner, then row, then channel
	assign end_col = c_cnt == KW'(KDIM - 1);
	assign end_row = end_col && r_cnt == KW'(KDIM - 1);
	assign end_beat = end_row && ch_cnt == CHW'(CHIN - 1);
	assign end_run = end_beat && win == WIN_W'(NWIN - 1);

	////////////////////////////////////////////////////////////
	// run control
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE, S_DONE: begin
					if (start)
						state <= S_RUN;
				end
				S_RUN: begin
					if (end_run)
						state <= S_DRAIN;
				end
				// wait for the last window to land in the result memory
				S_DRAIN: begin
					if (store_last)
						state <= S_DONE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// window walk, cleared whenever not running
	always_ff @(posedge clk) begin
		if (rst || !issue) begin
			c_cnt <= '0;
			r_cnt <= '0;
			ch_cnt <= '0;
			beat <= '0;
			wx <= '0;
			win <= '0;
			ref_addr <= '0;
			row_ref <= '0;
		end else begin
			c_cnt <= end_col ? '0 : c_cnt + 1'b1;
			if (end_col)
				r_cnt <= end_row ? '0 : r_cnt + 1'b1;
			if (end_row)
				ch_cnt <= end_beat ? '0 : ch_cnt + 1'b1;
			beat <= end_beat ? '0 : beat + 1'b1;
			if (end_beat) begin
				win <= win + 1'b1;
				// stride along the row, stride rows at row end
				if (wx == WXW'(WOUT - 1)) begin
					wx <= '0;
					row_ref <= row_ref + IMG_AW'(STRIDE * W_IN);
					ref_addr <= row_ref + IMG_AW'(STRIDE * W_IN);
				end else begin
					wx <= wx + 1'b1;
					ref_addr <= ref_addr + IMG_AW'(STRIDE);
				end
			end
		end
	end

	// channel plane, row and column offsets from the window origin
	assign img_addr = ref_addr + IMG_AW'(ch_cnt) * IMG_AW'(W_IN * W_IN)
		+ IMG_AW'(r_cnt) * IMG_AW'(W_IN) + IMG_AW'(c_cnt);

	////////////////////////////////////////////////////////////
	// operand fetch, one cycle behind the address
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst)
			strm.valid <= 1'b0;
		else
			strm.valid <= issue;
	end

	always_ff @(posedge clk) begin
		strm.first <= beat == '0;
		strm.last <= end_beat;
		strm.win <= win;
		strm.pix <= img_mem[img_addr];
		for (int i = 0; i < CHOUT; i++)
			strm.wgt[i] <= wgt_mem[WGT_AW'(i * K2C) + WGT_AW'(beat)];
	end

	// host port, writes locked out by the decoder during a run
	always_ff @(posedge clk) begin
		if (cfg.wr_en && cfg.tgt == T_IMG)
			img_mem[cfg.idx[IMG_AW-1:0]] <= cfg.wdata[PIX_W-1:0];
		if (cfg.wr_en && cfg.tgt == T_WGT)
			wgt_mem[cfg.idx[WGT_AW-1:0]] <= cfg.wdata[PIX_W-1:0];
		// sign extended readback
		if (cfg.rd_en && cfg.tgt == T_IMG)
			cfg.img_rd_data <= APB_DW'(img_mem[cfg.idx[IMG_AW-1:0]]);
		if (cfg.rd_en && cfg.tgt == T_WGT)
			cfg.wgt_rd_data <= APB_DW'(wgt_mem[cfg.idx[WGT_AW-1:0]]);
	end

endmodule

/* hdl/mac_array.sv */
// Parallel multiply-accumulate lanes
`timescale 1ns/1ps

module mac_array #(
	parameter int CHOUT = 4,
	parameter int WOUT = 4
) (
	input logic clk,
	input logic rst,
	conv_stream_if.snk strm,
	output logic acc_valid,
	output conv_geom_pkg::acc_t acc [CHOUT],
	output logic [$clog2(WOUT*WOUT)-1:0] acc_win
);
	import conv_geom_pkg::*;

	// sign extended products, one per lane
	acc_t prod [CHOUT];

	always_comb begin
		for (int i = 0; i < CHOUT; i++)
			prod[i] = acc_t'(strm.pix) * acc_t'(strm.wgt[i]);
	end

	////////////////////////////////////////////////////////////
	// lanes
	////////////////////////////////////////////////////////////

	// first beat loads, later beats add
	// sum holds for exactly the cycle after last
	always_ff @(posedge clk) begin
		if (strm.valid) begin
			for (int i = 0; i < CHOUT; i++)
				acc[i] <= strm.first ? prod[i] : acc[i] + prod[i];
		end
	end

	// one pulse per finished window
	always_ff @(posedge clk) begin
		if (rst)
			acc_valid <= 1'b0;
		else
			acc_valid <= strm.valid & strm.last;
	end

	always_ff @(posedge clk) begin
		if (strm.valid && strm.last)
			acc_win <= strm.win;
	end

endmodule

/* hdl/result_store.sv */
// Bias, ReLU, quantizer and result memory
`timescale 1ns/1ps

module result_store #(
	parameter int CHOUT = 4,
	parameter int WOUT = 4
) (
	input logic clk,
	input logic rst,
	cfg_bus_if.slave_bias_res cfg,
	input logic acc_valid,
	input conv_geom_pkg::acc_t acc [CHOUT],
	input logic [$clog2(WOUT*WOUT)-1:0] acc_win,
	output logic store_last
);
	import conv_geom_pkg::*;
	import conv_ctrl_pkg::*;

	localparam int NWIN = WOUT * WOUT;
	localparam int WIN_W = $clog2(NWIN);
	localparam int RES_WORDS = NWIN * CHOUT;
	localparam int BIAS_AW = $clog2(CHOUT);
	localparam int RES_AW = $clog2(RES_WORDS);
	// largest unsigned result
	localparam acc_t SAT_MAX = acc_t'((1 << OUT_W) - 1);

	acc_t bias_mem [CHOUT];
	// window-major, channels adjacent
	logic [OUT_W-1:0] res_mem [RES_WORDS];
	acc_t sum [CHOUT];
	logic [OUT_W-1:0] q [CHOUT];

	////////////////////////////////////////////////////////////
	// per channel post-processing
	////////////////////////////////////////////////////////////
	always_comb begin
		for (int i = 0; i < CHOUT; i++) begin
			sum[i] = acc[i] + bias_mem[i];
			// ReLU clamp
			if (sum[i][ACC_W-1])
				q[i] = '0;
			else if ((sum[i] >>> FRAC_BITS) > SAT_MAX)
				q[i] = '1;
			else
				q[i] = sum[i][FRAC_BITS +: OUT_W];
		end
	end

	// final window lands on this edge
	assign store_last = acc_valid && acc_win == WIN_W'(NWIN - 1);

	always_ff @(posedge clk) begin
		if (acc_valid) begin
			for (int i = 0; i < CHOUT; i++)
				res_mem[RES_AW'(acc_win) * RES_AW'(CHOUT) + RES_AW'(i)] <= q[i];
		end
	end

	// host port, bias sign extended and result zero extended
	always_ff @(posedge clk) begin
		if (cfg.wr_en && cfg.tgt == T_BIAS)
			bias_mem[cfg.idx[BIAS_AW-1:0]] <= cfg.wdata[ACC_W-1:0];
		if (cfg.rd_en && cfg.tgt == T_BIAS)
			cfg.bias_rd_data <= APB_DW'(bias_mem[cfg.idx[BIAS_AW-1:0]]);
		if (cfg.rd_en && cfg.tgt == T_RES)
			cfg.res_rd_data <= {{(APB_DW-OUT_W){1'b0}}, res_mem[cfg.idx[RES_AW-1:0]]};
	end

endmodule

/* hdl/conv_layer_top.sv */
// Stride-2 convolution layer top
`timescale 1ns/1ps

module conv_layer_top #(
	parameter int W_IN = conv_geom_pkg::W_IN_DEF,
	parameter int CHIN = conv_geom_pkg::CHIN_DEF,
	parameter int CHOUT = conv_geom_pkg::CHOUT_DEF,
	parameter int WOUT = conv_geom_pkg::WOUT_DEF
) (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [conv_ctrl_pkg::APB_AW-1:0] paddr,
	input logic [conv_ctrl_pkg::APB_DW-1:0] pwdata,
	output logic [conv_ctrl_pkg::APB_DW-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic irq
);
	import conv_geom_pkg::*;

	localparam int WIN_W = $clog2(WOUT * WOUT);

	// run handshake
	logic start;
	logic busy;
	logic done;
	logic store_last;
	// MAC to result link
	logic acc_valid;
	acc_t acc [CHOUT];
	logic [WIN_W-1:0] acc_win;

	cfg_bus_if cfg ();
	conv_stream_if #(.CHOUT(CHOUT), .WOUT(WOUT)) strm ();

	////////////////////////////////////////////////////////////
	// decode
	////////////////////////////////////////////////////////////
	apb_reg_decode #(.W_IN(W_IN), .CHIN(CHIN), .CHOUT(CHOUT), .WOUT(WOUT)) u_decode (
		.clk(clk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr),
		.busy(busy), .done(done), .start(start),
		.cfg(cfg)
	);

	////////////////////////////////////////////////////////////
	// execute
	////////////////////////////////////////////////////////////
	window_sequencer #(.W_IN(W_IN), .CHIN(CHIN), .CHOUT(CHOUT), .WOUT(WOUT)) u_seq (
		.clk(clk), .rst(rst), .start(start), .store_last(store_last),
		.busy(busy), .done(done), .cfg(cfg), .strm(strm)
	);

	mac_array #(.CHOUT(CHOUT), .WOUT(WOUT)) u_mac (
		.clk(clk), .rst(rst), .strm(strm),
		.acc_valid(acc_valid), .acc(acc), .acc_win(acc_win)
	);

	////////////////////////////////////////////////////////////
	// result
	////////////////////////////////////////////////////////////
	result_store #(.CHOUT(CHOUT), .WOUT(WOUT)) u_res (
		.clk(clk), .rst(rst), .cfg(cfg),
		.acc_valid(acc_valid), .acc(acc), .acc_win(acc_win),
		.store_last(store_last)
	);

	// level interrupt, held until the next start
	assign irq = done;

endmodule

/* testbench/conv_layer_assert.sv */
// Bound convolution and APB checker
`timescale 1ns/1ps

module conv_layer_assert #(
	parameter int W_IN = 9,
	parameter int CHIN = 2,
	parameter int CHOUT = 4,
	parameter int WOUT = 4
) (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [conv_ctrl_pkg::APB_AW-1:0] paddr,
	input logic [conv_ctrl_pkg::APB_DW-1:0] pwdata,
	input logic [conv_ctrl_pkg::APB_DW-1:0] prdata,
	input logic pready,
	input logic pslverr,
	input logic irq
);
	import conv_geom_pkg::*;
	import conv_ctrl_pkg::*;

	localparam int IMG_N = W_IN * W_IN * CHIN;
	localparam int K2C = KDIM * KDIM * CHIN;
	localparam int WGT_N = CHOUT * K2C;
	localparam int RES_N = WOUT * WOUT * CHOUT;
	// edges from the start write to the edge that sets done
	localparam int RUN_EDGES = WOUT * WOUT * K2C + 2;

	// shadow storage from accepted writes
	logic signed [PIX_W-1:0] img_sh [IMG_N];
	logic signed [PIX_W-1:0] wgt_sh [WGT_N];
	logic signed [ACC_W-1:0] bias_sh [CHOUT];
	// expected run state
	logic busy_m;
	logic done_m;
	int run_cnt;
	// last cycle was an access with pready low
	logic in_wait;
	logic xfer;
	logic start_acc;
	int widx;
	// count of fired assertions
	int fail_cnt = 0;

	////////////////////////////////////////////////////////////
	// address map
	////////////////////////////////////////////////////////////
	function automatic target_e target_of(logic [APB_AW-1:0] a);
		int i;
		i = int'(a[9:2]);
		if (a == CTRL_ADDR)
			return T_CTRL;
		if (a == STATUS_ADDR)
			return T_STATUS;
		if (a[1:0] != 2'b00)
			return T_BAD;
		// 1 KiB regions with the index bounded by each memory size
		if (a[APB_AW-1:10] == IMG_BASE[APB_AW-1:10] && i < IMG_N)
			return T_IMG;
		if (a[APB_AW-1:10] == WGT_BASE[APB_AW-1:10] && i < WGT_N)
			return T_WGT;
		if (a[APB_AW-1:10] == BIAS_BASE[APB_AW-1:10] && i < CHOUT)
			return T_BIAS;
		if (a[APB_AW-1:10] == RES_BASE[APB_AW-1:10] && i < RES_N)
			return T_RES;
		return T_BAD;
	endfunction

	function automatic logic err_of(logic [APB_AW-1:0] a, logic wr, logic bsy);
		case (target_of(a))
			T_BAD: return 1'b1;
			T_STATUS, T_RES: return wr;
			// memories locked during a run
			T_IMG, T_WGT, T_BIAS: return wr & bsy;
			default: return 1'b0;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// reference convolution
	////////////////////////////////////////////////////////////
	function automatic logic [APB_DW-1:0] conv_out(int r);
		int win;
		int ch;
		int oy;
		int ox;
		int s;
		win = r / CHOUT;
		ch = r % CHOUT;
		oy = win / WOUT;
		ox = win % WOUT;
		s = 0;
		for (int c = 0; c < CHIN; c++)
			for (int ky = 0; ky < KDIM; ky++)
				for (int kx = 0; kx < KDIM; kx++)
					s += img_sh[c * W_IN * W_IN + (oy * STRIDE + ky) * W_IN + ox * STRIDE + kx]
						* wgt_sh[ch * K2C + (c * KDIM + ky) * KDIM + kx];
		s += bias_sh[ch];
		// ReLU then drop the fraction and clip to 8 bits
		if (s < 0)
			return '0;
		s = s >>> FRAC_BITS;
		return (s > 255) ? 255 : s;
	endfunction

	function automatic logic [APB_DW-1:0] exp_rdata(logic [APB_AW-1:0] a, logic bsy, logic dn);
		int i;
		i = int'(a[9:2]);
		case (target_of(a))
			T_CTRL: return {{(APB_DW-1){1'b0}}, bsy};
			T_STATUS: return {{(APB_DW-2){1'b0}}, dn, bsy};
			// signed memories read back sign extended
			T_IMG: return APB_DW'(img_sh[i]);
			T_WGT: return APB_DW'(wgt_sh[i]);
			T_BIAS: return APB_DW'(bias_sh[i]);
			T_RES: return conv_out(i);
			default: return '0;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// shadow model
	////////////////////////////////////////////////////////////
	assign xfer = psel & penable & pready;
	assign start_acc = xfer & pwrite & (paddr == CTRL_ADDR) & pwdata[0] & ~busy_m;
	assign widx = int'(paddr[9:2]);

	always @(posedge clk) begin
		if (rst) begin
			busy_m <= 1'b0;
			done_m <= 1'b0;
			run_cnt <= 0;
			in_wait <= 1'b0;
		end else begin
			in_wait <= psel & penable & ~pready;
			if (start_acc) begin
				busy_m <= 1'b1;
				done_m <= 1'b0;
				run_cnt <= RUN_EDGES - 1;
			end else if (busy_m) begin
				if (run_cnt == 0) begin
					busy_m <= 1'b0;
					done_m <= 1'b1;
				end else begin
					run_cnt <= run_cnt - 1;
				end
			end
			// rejected writes leave the shadow alone
			if (xfer && pwrite && !err_of(paddr, 1'b1, busy_m)) begin
				case (target_of(paddr))
					T_IMG: img_sh[widx] <= pwdata[PIX_W-1:0];
					T_WGT: wgt_sh[widx] <= pwdata[PIX_W-1:0];
					T_BIAS: bias_sh[widx] <= pwdata[ACC_W-1:0];
					default: ;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////
	a_idle: assert property (@(posedge clk) disable iff (rst)
		!(psel && penable) |-> !pready && !pslverr)
	else begin
		fail_cnt++;
		$error("[FAIL] idle pready expected 0 got %h pslverr expected 0 got %h",
			pready, pslverr);
	end

	a_err: assert property (@(posedge clk) disable iff (rst)
		xfer |-> pslverr == err_of(paddr, pwrite, busy_m))
	else begin
		fail_cnt++;
		$error("[FAIL] pslverr at %h expected %h got %h", paddr,
			err_of(paddr, pwrite, busy_m), pslverr);
	end

	a_rdata: assert property (@(posedge clk) disable iff (rst)
		xfer && !pwrite && !pslverr |-> prdata == exp_rdata(paddr, busy_m, done_m))
	else begin
		fail_cnt++;
		$error("[FAIL] prdata at %h expected %h got %h", paddr,
			exp_rdata(paddr, busy_m, done_m), prdata);
	end

	// memory reads wait exactly one cycle and all else none
	a_wait: assert property (@(posedge clk) disable iff (rst)
		xfer |-> in_wait == (!pwrite && target_of(paddr) inside {T_IMG, T_WGT, T_BIAS, T_RES}))
	else begin
		fail_cnt++;
		$error("[FAIL] pready wait at %h expected %h got %h", paddr,
			!pwrite && target_of(paddr) inside {T_IMG, T_WGT, T_BIAS, T_RES}, in_wait);
	end

	a_stall_once: assert property (@(posedge clk) disable iff (rst)
		psel && penable && !pready |=> pready)
	else begin
		fail_cnt++;
		$error("pready stayed low for more than one wait cycle");
	end

	a_irq: assert property (@(posedge clk) disable iff (rst)
		irq == done_m)
	else begin
		fail_cnt++;
		$error("[FAIL] irq expected %h got %h", done_m, irq);
	end

endmodule

/* testbench/tb_conv_layer.sv */
// Convolution layer testbench
`timescale 1ns/1ps

module tb_conv_layer;
	import conv_geom_pkg::*;
	import conv_ctrl_pkg::*;

	localparam int IMG_N = W_IN_DEF * W_IN_DEF * CHIN_DEF;
	localparam int K2C = KDIM * KDIM * CHIN_DEF;
	localparam int WGT_N = CHOUT_DEF * K2C;
	localparam int RES_N = WOUT_DEF * WOUT_DEF * CHOUT_DEF;
	localparam int RUN_CYC = WOUT_DEF * WOUT_DEF * K2C + 3;
	// loads at 3 cycles per write and 4 per readback plus probe slack
	localparam int ONE_PASS = (IMG_N + WGT_N + CHOUT_DEF) * 7 + RUN_CYC + RES_N * 4 + 64;
	// both runs with a twofold margin
	localparam int LIMIT = 2 * 2 * ONE_PASS;

	logic clk = 1'b0;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [APB_AW-1:0] paddr;
	logic [APB_DW-1:0] pwdata;
	logic [APB_DW-1:0] prdata;
	logic pready;
	logic pslverr;
	logic irq;
	logic [31:0] lfsr;
	int cycles = 0;

	conv_layer_top u_dut (
		.clk(clk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr), .irq(irq)
	);

	// checker sees only the top-level ports
	bind conv_layer_top conv_layer_assert #(
		.W_IN(W_IN), .CHIN(CHIN), .CHOUT(CHOUT), .WOUT(WOUT)
	) u_assert (
		.clk(clk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr), .irq(irq)
	);

	always #5 clk = ~clk;

	////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////

	// galois lfsr x^32+x^22+x^2+x+1 stepped once per bit
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// access phase held until pready
	task automatic finish_access();
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		while (!pready)
			@(negedge clk);
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic write_word(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
		@(posedge clk);
		psel <= 1'b1;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		finish_access();
	endtask

	task automatic read_word(input logic [APB_AW-1:0] addr);
		@(posedge clk);
		psel <= 1'b1;
		pwrite <= 1'b0;
		paddr <= addr;
		finish_access();
	endtask

	// random bytes into a memory and every word read back
	task automatic fill_memory(input logic [APB_AW-1:0] base, input int n);
		for (int i = 0; i < n; i++)
			write_word(base + APB_AW'(i * 4), rand_bits(8));
		for (int i = 0; i < n; i++)
			read_word(base + APB_AW'(i * 4));
	endtask

	// large negative bias on ch0 and large positive bias on ch1
	task automatic load_bias();
		logic [31:0] b;
		write_word(BIAS_BASE, 32'hFFFC_0000);
		write_word(BIAS_BASE + 16'd4, 32'h0004_0000);
		for (int ch = 2; ch < CHOUT_DEF; ch++) begin
			b = rand_bits(12);
			write_word(BIAS_BASE + APB_AW'(ch * 4), {{20{b[11]}}, b[11:0]});
		end
		for (int ch = 0; ch < CHOUT_DEF; ch++)
			read_word(BIAS_BASE + APB_AW'(ch * 4));
	endtask

	task automatic run_layer(input bit probe);
		write_word(CTRL_ADDR, 32'h1);
		// busy set and done cleared
		read_word(STATUS_ADDR);
		if (probe) begin
			// unmapped and read-only targets, then locked weights
			write_word(16'h2000, 32'h1);
			read_word(16'h0008);
			write_word(IMG_BASE + APB_AW'(IMG_N * 4), 32'h11);
			write_word(RES_BASE, 32'h5A);
			write_word(WGT_BASE + 16'd4, 32'h7F);
			read_word(WGT_BASE + 16'd4);
			read_word(STATUS_ADDR);
		end
		// status polled through the whole run
		while (!irq)
			read_word(STATUS_ADDR);
		read_word(STATUS_ADDR);
		for (int r = 0; r < RES_N; r++)
			read_word(RES_BASE + APB_AW'(r * 4));
	endtask

	////////////////////////////////////////////////////////////
	// failure watch and timeout
	////////////////////////////////////////////////////////////
	always @(negedge clk) begin
		if (u_dut.u_assert.fail_cnt != 0) begin
			$display("TEST FAILED");
			$fatal(1, "checker assertion fired");
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > LIMIT) begin
			$display("TEST FAILED");
			$fatal(1, "run did not finish within %0d cycles", LIMIT);
		end
	end

	initial begin
		lfsr = 32'h3e962374;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		// idle state after reset
		read_word(STATUS_ADDR);
		read_word(CTRL_ADDR);
		fill_memory(IMG_BASE, IMG_N);
		fill_memory(WGT_BASE, WGT_N);
		load_bias();
		run_layer(1'b1);
		// second run with fresh weights
		fill_memory(WGT_BASE, WGT_N);
		run_layer(1'b0);
		repeat (2) @(posedge clk);
		if (u_dut.u_assert.fail_cnt == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			$display("TEST FAILED");
			$fatal(1, "checker reported a mismatch");
		end
	end

endmodule

/* src.f */
hdl/conv_geom_pkg.sv
hdl/conv_ctrl_pkg.sv
hdl/conv_stream_if.sv
hdl/cfg_bus_if.sv
hdl/apb_reg_decode.sv
hdl/window_sequencer.sv
hdl/mac_array.sv
hdl/result_store.sv
hdl/conv_layer_top.sv
testbench/conv_layer_assert.sv
testbench/tb_conv_layer.sv

/* Makefile */
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_conv_layer -f src.f

run: compile
	./obj_dir/Vtb_conv_layer +verilator+error+limit+1000 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || { echo "simulation ended without passing"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
